//--- include/matchedFilter_defs.svh
`ifndef MATCHEDFILTER_DEFS_SVH
`define MATCHEDFILTER_DEFS_SVH

// width of one real sample component.
`define MF_DATA_WIDTH 18

// matched-filter length in complex taps.
`define MF_TAPS 16

// memory layout.
`define MF_ADDR_WIDTH 10
`define MF_COEFF_BASE 0
`define MF_DATA_BASE 64

// hilbert transformer coefficients and output scaling.
`define MF_HT_SHIFT 4
`define MF_HT_C1 10
`define MF_HT_C3 3

// arithmetic right shift applied to every FIR sum.
`define MF_OUT_SHIFT 12

`endif

//--- source/mfSamplePkg.sv
`include "matchedFilter_defs.svh"

package mfSamplePkg;

	// one signed real sample.
	typedef logic signed [`MF_DATA_WIDTH - 1:0] sampleT;

	// im sits in the upper half so a memory word casts straight onto it.
	typedef struct packed {
		sampleT im;
		sampleT re;
	} complexSampleT;

	// one component of a scaled FIR result.
	typedef logic signed [2 * `MF_DATA_WIDTH - 1:0] wideT;

	typedef struct packed {
		wideT im;
		wideT re;
	} complexResultT;

	// magnitude of a complex result.
	typedef logic [2 * `MF_DATA_WIDTH - 1:0] magnitudeT;

endpackage

//--- source/mfMemoryPkg.sv
`include "matchedFilter_defs.svh"

package mfMemoryPkg;

	// coefficients use both halves, data samples only the low half.
	typedef logic [2 * `MF_DATA_WIDTH - 1:0] memWordT;
	typedef logic [`MF_ADDR_WIDTH - 1:0] memAddrT;

	typedef struct packed {
		logic valid;
		memAddrT address;
		memWordT word;
	} hostWriteT;

	typedef struct packed {
		logic valid;
		memAddrT address;
	} readRequestT;

	typedef enum logic [1:0] {
		idle,
		loadCoeff,
		streamData,
		drain
	} sequencerStateT;

endpackage

//--- source/sampleMemory.sv
`include "matchedFilter_defs.svh"

module sampleMemory (
	input logic clock,
	input logic writeEnable,
	input mfMemoryPkg::memAddrT address,
	input mfMemoryPkg::memWordT writeWord,
	output mfMemoryPkg::memWordT readWord
);

	import mfMemoryPkg::*;

	localparam int Depth = 1 << `MF_ADDR_WIDTH;

	memWordT storage [0:Depth - 1];

	// read returns the old word when a write hits the same address.
	always_ff @(posedge clock) begin
		if (writeEnable) begin
			storage[address] <= writeWord;
		end
		readWord <= storage[address];
	end

endmodule

//--- source/memoryArbiter.sv
module memoryArbiter (
	input logic clock,
	input logic arstN,
	input mfMemoryPkg::hostWriteT hostWrite,
	input mfMemoryPkg::readRequestT coeffRequest,
	input mfMemoryPkg::readRequestT dataRequest,
	output logic hostGrant,
	output logic coeffGrant,
	output logic dataGrant,
	output logic coeffReturnValid,
	output logic dataReturnValid,
	output logic memWriteEnable,
	output mfMemoryPkg::memAddrT memAddress,
	output mfMemoryPkg::memWordT memWriteWord
);

	import mfMemoryPkg::*;

	// set when the data reader had the last read slot.
	logic dataServedLast;

	// host always wins, readers take turns when both ask.
	always_comb begin
		hostGrant = hostWrite.valid;
		coeffGrant = 1'b0;
		dataGrant = 1'b0;
		if (!hostWrite.valid) begin
			if (coeffRequest.valid && dataRequest.valid) begin
				coeffGrant = dataServedLast;
				dataGrant = !dataServedLast;
			end else begin
				coeffGrant = coeffRequest.valid;
				dataGrant = dataRequest.valid;
			end
		end
	end

	assign memWriteEnable = hostGrant;
	assign memWriteWord = hostWrite.word;

	always_comb begin
		if (hostGrant) begin
			memAddress = hostWrite.address;
		end else if (coeffGrant) begin
			memAddress = coeffRequest.address;
		end else begin
			memAddress = dataRequest.address;
		end
	end

	// the memory answers one cycle later, so the grant is echoed as a return strobe.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			dataServedLast <= 1'b0;
			coeffReturnValid <= 1'b0;
			dataReturnValid <= 1'b0;
		end else begin
			coeffReturnValid <= coeffGrant;
			dataReturnValid <= dataGrant;
			if (coeffGrant) begin
				dataServedLast <= 1'b0;
			end else if (dataGrant) begin
				dataServedLast <= 1'b1;
			end
		end
	end

endmodule

//--- source/memoryReader.sv
module memoryReader #(
	parameter type PayloadT = logic
) (
	input logic clock,
	input logic arstN,
	input logic start,
	input mfMemoryPkg::memAddrT baseAddress,
	input mfMemoryPkg::memAddrT length,
	input logic grant,
	input logic returnValid,
	input mfMemoryPkg::memWordT readWord,
	output mfMemoryPkg::readRequestT request,
	output PayloadT payload,
	output logic payloadValid,
	output logic regionDone
);

	import mfMemoryPkg::*;

	memAddrT address;
	memAddrT remaining;
	logic waiting;
	logic lastPayload;

	// one read in flight at a time keeps payloads in address order.
	assign request.valid = (remaining != '0) && !waiting;
	assign request.address = address;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			address <= '0;
			remaining <= '0;
			waiting <= 1'b0;
			payloadValid <= 1'b0;
			lastPayload <= 1'b0;
			regionDone <= 1'b0;
		end else begin
			payloadValid <= returnValid;
			// nothing left to request means this return is the final word.
			lastPayload <= returnValid && (remaining == '0);
			regionDone <= lastPayload;
			if (start) begin
				address <= baseAddress;
				remaining <= length;
				waiting <= 1'b0;
			end else if (grant) begin
				address <= address + 1'b1;
				remaining <= remaining - 1'b1;
				waiting <= 1'b1;
			end else if (returnValid) begin
				waiting <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (returnValid) begin
			payload <= PayloadT'(readWord[$bits(PayloadT) - 1:0]);
		end
	end

endmodule

//--- source/hilbertTransform.sv
`include "matchedFilter_defs.svh"

module hilbertTransform (
	input logic clock,
	input logic arstN,
	input mfSamplePkg::sampleT sampleIn,
	input logic sampleValid,
	input logic clear,
	output mfSamplePkg::complexSampleT analyticOut,
	output logic analyticValid
);

	import mfSamplePkg::*;

	localparam int Length = 7;

	// history[0] is the sample one strobe back.
	sampleT history [0:Length - 2];
	sampleT window [0:Length - 1];
	logic signed [`MF_DATA_WIDTH + 7:0] imagSum;

	// the incoming sample plus the stored history form the seven-sample window.
	always_comb begin
		window[0] = sampleIn;
		for (int k = 1; k < Length; k++) begin
			window[k] = history[k - 1];
		end
	end

	// odd taps only, antisymmetric about the centre sample.
	assign imagSum = `MF_HT_C3 * (window[0] - window[6]) + `MF_HT_C1 * (window[2] - window[4]);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < Length - 1; k++) begin
				history[k] <= '0;
			end
			analyticValid <= 1'b0;
		end else begin
			analyticValid <= sampleValid;
			if (clear) begin
				// new run starts from zero history.
				for (int k = 0; k < Length - 1; k++) begin
					history[k] <= '0;
				end
			end else if (sampleValid) begin
				for (int k = 0; k < Length - 1; k++) begin
					history[k] <= window[k];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (sampleValid) begin
			analyticOut.re <= window[3];
			analyticOut.im <= sampleT'(imagSum >>> `MF_HT_SHIFT);
		end
	end

endmodule

//--- source/complexFir.sv
`include "matchedFilter_defs.svh"

module complexFir (
	input logic clock,
	input logic arstN,
	input mfSamplePkg::complexSampleT coeffIn,
	input logic coeffValid,
	input mfSamplePkg::complexSampleT analyticIn,
	input logic analyticValid,
	output mfSamplePkg::complexResultT resultOut,
	output logic resultValid
);

	import mfSamplePkg::*;

	localparam int Taps = `MF_TAPS;
	// product width plus growth for the sum of two terms per tap.
	localparam int SumWidth = 2 * `MF_DATA_WIDTH + $clog2(Taps) + 2;

	complexSampleT coeffLine [0:Taps - 1];
	complexSampleT sampleLine [0:Taps - 2];
	complexSampleT window [0:Taps - 1];
	logic signed [SumWidth - 1:0] sumRe;
	logic signed [SumWidth - 1:0] sumIm;

	// window[k] is the analytic sample k strobes back.
	always_comb begin
		window[0] = analyticIn;
		for (int k = 1; k < Taps; k++) begin
			window[k] = sampleLine[k - 1];
		end
	end

	// full-precision complex multiply-accumulate over all taps.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < Taps; k++) begin
			sumRe = sumRe + window[k].re * coeffLine[k].re - window[k].im * coeffLine[k].im;
			sumIm = sumIm + window[k].re * coeffLine[k].im + window[k].im * coeffLine[k].re;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < Taps; k++) begin
				coeffLine[k] <= '0;
			end
			for (int k = 0; k < Taps - 1; k++) begin
				sampleLine[k] <= '0;
			end
			resultValid <= 1'b0;
		end else begin
			resultValid <= analyticValid;
			if (coeffValid) begin
				// first coefficient loaded ends up at the oldest tap.
				coeffLine[0] <= coeffIn;
				for (int k = 1; k < Taps; k++) begin
					coeffLine[k] <= coeffLine[k - 1];
				end
				// a coefficient load starts a new run with empty history.
				for (int k = 0; k < Taps - 1; k++) begin
					sampleLine[k] <= '0;
				end
			end else if (analyticValid) begin
				for (int k = 0; k < Taps - 1; k++) begin
					sampleLine[k] <= window[k];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (analyticValid) begin
			resultOut.re <= wideT'(sumRe >>> `MF_OUT_SHIFT);
			resultOut.im <= wideT'(sumIm >>> `MF_OUT_SHIFT);
		end
	end

endmodule

//--- source/magnitudeEstimator.sv
module magnitudeEstimator (
	input logic clock,
	input logic arstN,
	input mfSamplePkg::complexResultT resultIn,
	input logic resultValid,
	output mfSamplePkg::magnitudeT magnitude,
	output logic magnitudeValid
);

	import mfSamplePkg::*;

	magnitudeT absRe;
	magnitudeT absIm;
	magnitudeT larger;
	magnitudeT smaller;

	// negating the most negative value still gives the right unsigned pattern.
	assign absRe = resultIn.re[$bits(wideT) - 1] ? magnitudeT'(-resultIn.re) : magnitudeT'(resultIn.re);
	assign absIm = resultIn.im[$bits(wideT) - 1] ? magnitudeT'(-resultIn.im) : magnitudeT'(resultIn.im);
	assign larger = (absRe > absIm) ? absRe : absIm;
	assign smaller = (absRe > absIm) ? absIm : absRe;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			magnitude <= '0;
			magnitudeValid <= 1'b0;
		end else begin
			magnitudeValid <= resultValid;
			if (resultValid) begin
				magnitude <= larger + (smaller >> 1);
			end
		end
	end

endmodule

//--- source/filterSequencer.sv
module filterSequencer (
	input logic clock,
	input logic arstN,
	input logic start,
	input logic coeffDone,
	input logic dataDone,
	output logic coeffStart,
	output logic dataStart,
	output logic busy,
	output logic done
);

	import mfMemoryPkg::*;

	sequencerStateT state;
	logic drainCount;

	// start is only looked at in idle, so a request while busy is dropped.
	assign busy = (state != idle);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			drainCount <= 1'b0;
			coeffStart <= 1'b0;
			dataStart <= 1'b0;
			done <= 1'b0;
		end else begin
			coeffStart <= 1'b0;
			dataStart <= 1'b0;
			done <= 1'b0;
			case (state)
				idle: begin
					if (start) begin
						state <= loadCoeff;
						coeffStart <= 1'b1;
					end
				end
				loadCoeff: begin
					if (coeffDone) begin
						state <= streamData;
						dataStart <= 1'b1;
					end
				end
				streamData: begin
					if (dataDone) begin
						state <= drain;
						drainCount <= 1'b0;
					end
				end
				drain: begin
					// hilbert, FIR and magnitude stages empty out here.
					if (drainCount) begin
						state <= idle;
						done <= 1'b1;
					end else begin
						drainCount <= 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

//--- source/matchedFilter.sv
`include "matchedFilter_defs.svh"

module matchedFilter (
	input logic clock,
	input logic arstN,
	input logic start,
	input mfMemoryPkg::memAddrT dataLength,
	input mfMemoryPkg::hostWriteT hostWrite,
	output logic hostGrant,
	output mfSamplePkg::magnitudeT magnitude,
	output logic magnitudeValid,
	output logic busy,
	output logic done
);

	import mfSamplePkg::*;
	import mfMemoryPkg::*;

	logic memWriteEnable;
	memAddrT memAddress;
	memWordT memWriteWord;
	memWordT memReadWord;

	readRequestT coeffRequest;
	readRequestT dataRequest;
	logic coeffGrant;
	logic dataGrant;
	logic coeffReturnValid;
	logic dataReturnValid;

	logic coeffStart;
	logic dataStart;
	logic coeffDone;
	logic dataDone;

	complexSampleT coeffSample;
	logic coeffValid;
	sampleT dataSample;
	logic dataValid;
	complexSampleT analytic;
	logic analyticValid;
	complexResultT firResult;
	logic firResultValid;

	sampleMemory memory (
		.clock(clock),
		.writeEnable(memWriteEnable),
		.address(memAddress),
		.writeWord(memWriteWord),
		.readWord(memReadWord)
	);

	memoryArbiter arbiter (
		.clock(clock),
		.arstN(arstN),
		.hostWrite(hostWrite),
		.coeffRequest(coeffRequest),
		.dataRequest(dataRequest),
		.hostGrant(hostGrant),
		.coeffGrant(coeffGrant),
		.dataGrant(dataGrant),
		.coeffReturnValid(coeffReturnValid),
		.dataReturnValid(dataReturnValid),
		.memWriteEnable(memWriteEnable),
		.memAddress(memAddress),
		.memWriteWord(memWriteWord)
	);

	memoryReader #(
		.PayloadT(complexSampleT)
	) coeffReader (
		.clock(clock),
		.arstN(arstN),
		.start(coeffStart),
		.baseAddress(memAddrT'(`MF_COEFF_BASE)),
		.length(memAddrT'(`MF_TAPS)),
		.grant(coeffGrant),
		.returnValid(coeffReturnValid),
		.readWord(memReadWord),
		.request(coeffRequest),
		.payload(coeffSample),
		.payloadValid(coeffValid),
		.regionDone(coeffDone)
	);

	memoryReader #(
		.PayloadT(sampleT)
	) dataReader (
		.clock(clock),
		.arstN(arstN),
		.start(dataStart),
		.baseAddress(memAddrT'(`MF_DATA_BASE)),
		.length(dataLength),
		.grant(dataGrant),
		.returnValid(dataReturnValid),
		.readWord(memReadWord),
		.request(dataRequest),
		.payload(dataSample),
		.payloadValid(dataValid),
		.regionDone(dataDone)
	);

	hilbertTransform hilbert (
		.clock(clock),
		.arstN(arstN),
		.sampleIn(dataSample),
		.sampleValid(dataValid),
		.clear(dataStart),
		.analyticOut(analytic),
		.analyticValid(analyticValid)
	);

	complexFir fir (
		.clock(clock),
		.arstN(arstN),
		.coeffIn(coeffSample),
		.coeffValid(coeffValid),
		.analyticIn(analytic),
		.analyticValid(analyticValid),
		.resultOut(firResult),
		.resultValid(firResultValid)
	);

	magnitudeEstimator estimator (
		.clock(clock),
		.arstN(arstN),
		.resultIn(firResult),
		.resultValid(firResultValid),
		.magnitude(magnitude),
		.magnitudeValid(magnitudeValid)
	);

	filterSequencer sequencer (
		.clock(clock),
		.arstN(arstN),
		.start(start),
		.coeffDone(coeffDone),
		.dataDone(dataDone),
		.coeffStart(coeffStart),
		.dataStart(dataStart),
		.busy(busy),
		.done(done)
	);

endmodule

//--- verif/matchedFilterTb.sv
`include "matchedFilter_defs.svh"

module matchedFilterTb;

	import mfSamplePkg::*;
	import mfMemoryPkg::*;

	localparam int ClockPeriod = 4;
	localparam int ResetCycles = 16;
	localparam int Depth = 1 << `MF_ADDR_WIDTH;
	localparam int ImpulseLength = 24;
	localparam int RandomLength = 40;
	localparam int HostBlock = 20;
	localparam int OverlapLength = RandomLength + HostBlock;
	localparam int FirstLength = 30;
	localparam int SecondLength = 12;
	localparam int TotalLength = ImpulseLength + 2 * RandomLength + OverlapLength
		+ FirstLength + SecondLength;
	// roughly two cycles per sample plus a margin for coefficient loads and host writes.
	localparam int WatchdogCycles = 4 * TotalLength + 2000;

	logic clock;
	logic arstN;
	logic start;
	memAddrT dataLength;
	hostWriteT hostWrite;
	logic hostGrant;
	magnitudeT magnitude;
	logic magnitudeValid;
	logic busy;
	logic done;

	memWordT tbMemory [0:Depth - 1];
	magnitudeT expectedQueue [$];
	string currentTest;
	int magnitudeCount = 0;
	int checkTotal = 0;
	int errorCount = 0;

	matchedFilter i_dut (
		.clock(clock),
		.arstN(arstN),
		.start(start),
		.dataLength(dataLength),
		.hostWrite(hostWrite),
		.hostGrant(hostGrant),
		.magnitude(magnitude),
		.magnitudeValid(magnitudeValid),
		.busy(busy),
		.done(done)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(ClockPeriod / 2) clock = ~clock;
		end
	end

	// real sample n of the data region, zero before the first one.
	function automatic sampleT dataAt(int n);
		if (n < 0) begin
			return '0;
		end
		return sampleT'(tbMemory[`MF_DATA_BASE + n][`MF_DATA_WIDTH - 1:0]);
	endfunction

	function automatic complexSampleT hilbertAt(int n);
		complexSampleT result;
		longint imag;
		if (n < 0) begin
			return '0;
		end
		imag = `MF_HT_C3 * (longint'(dataAt(n)) - longint'(dataAt(n - 6)))
			+ `MF_HT_C1 * (longint'(dataAt(n - 2)) - longint'(dataAt(n - 4)));
		result.re = dataAt(n - 3);
		result.im = sampleT'(imag >>> `MF_HT_SHIFT);
		return result;
	endfunction

	function automatic complexResultT firAt(int n);
		complexResultT result;
		complexSampleT sample;
		complexSampleT coeff;
		longint sumRe;
		longint sumIm;
		sumRe = 0;
		sumIm = 0;
		for (int k = 0; k < `MF_TAPS; k++) begin
			sample = hilbertAt(n - k);
			// the first coefficient in memory meets the oldest sample.
			coeff = complexSampleT'(tbMemory[`MF_COEFF_BASE + `MF_TAPS - 1 - k]);
			sumRe += longint'(sample.re) * longint'(coeff.re)
				- longint'(sample.im) * longint'(coeff.im);
			sumIm += longint'(sample.re) * longint'(coeff.im)
				+ longint'(sample.im) * longint'(coeff.re);
		end
		result.re = wideT'(sumRe >>> `MF_OUT_SHIFT);
		result.im = wideT'(sumIm >>> `MF_OUT_SHIFT);
		return result;
	endfunction

	// larger part plus half the smaller one.
	function automatic magnitudeT magnitudeOf(complexResultT r);
		longint absRe;
		longint absIm;
		longint larger;
		longint smaller;
		absRe = (r.re < 0) ? -longint'(r.re) : longint'(r.re);
		absIm = (r.im < 0) ? -longint'(r.im) : longint'(r.im);
		larger = (absRe > absIm) ? absRe : absIm;
		smaller = (absRe > absIm) ? absIm : absRe;
		return magnitudeT'(larger + (smaller >> 1));
	endfunction

	task automatic buildExpected(int length);
		expectedQueue.delete();
		for (int n = 0; n < length; n++) begin
			expectedQueue.push_back(magnitudeOf(firAt(n)));
		end
	endtask

	task automatic checkMagnitude(string testName, magnitudeT expected, magnitudeT actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error %s: expected magnitude %0d, actual %0d", testName, expected, actual);
		end
	endtask

	task automatic checkCount(string testName, memAddrT expected, memAddrT actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error %s: expected %0d magnitudes, actual %0d", testName, expected, actual);
		end
	endtask

	// every magnitude is matched against the next expected value.
	initial begin
		forever begin
			@(negedge clock);
			if (magnitudeValid === 1'b1) begin
				magnitudeCount++;
				if (expectedQueue.size() == 0) begin
					errorCount++;
					$display("%s: a magnitude arrived with no expected value pending",
						currentTest);
				end else begin
					checkMagnitude(currentTest, expectedQueue.pop_front(), magnitude);
				end
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
		$display("Checks: %0d, errors: %0d", checkTotal, errorCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic checkIdle();
		repeat (20) begin
			@(negedge clock);
			checkTotal++;
			if (magnitudeValid !== 1'b0 || busy !== 1'b0 || done !== 1'b0
				|| hostGrant !== 1'b0) begin
				errorCount++;
				$display("%s: an output went active with no activity after reset", currentTest);
			end
		end
	endtask

	// host write through the DUT port, mirrored into the model memory.
	task automatic hostWriteWord(memAddrT address, memWordT word);
		int waitCycles;
		waitCycles = 0;
		@(negedge clock);
		hostWrite.valid = 1'b1;
		hostWrite.address = address;
		hostWrite.word = word;
		tbMemory[address] = word;
		@(posedge clock);
		while (hostGrant !== 1'b1 && waitCycles < 100) begin
			@(posedge clock);
			waitCycles++;
		end
		checkTotal++;
		if (hostGrant !== 1'b1) begin
			errorCount++;
			$display("%s: host write to address %0d was never granted", currentTest, address);
		end
		@(negedge clock);
		hostWrite.valid = 1'b0;
	endtask

	task automatic loadImpulseCoefficients();
		for (int k = 0; k < `MF_TAPS; k++) begin
			hostWriteWord(memAddrT'(`MF_COEFF_BASE + k),
				(k == 0) ? memWordT'(1 << `MF_OUT_SHIFT) : '0);
		end
	endtask

	task automatic loadRandomCoefficients();
		memWordT word;
		for (int k = 0; k < `MF_TAPS; k++) begin
			word = memWordT'({$urandom(), $urandom()});
			hostWriteWord(memAddrT'(`MF_COEFF_BASE + k), word);
		end
	endtask

	task automatic loadRandomData(int first, int count);
		memWordT word;
		for (int i = 0; i < count; i++) begin
			word = '0;
			word[`MF_DATA_WIDTH - 1:0] = sampleT'($urandom());
			hostWriteWord(memAddrT'(`MF_DATA_BASE + first + i), word);
		end
	endtask

	task automatic runFilter(string testName, int length, bit extraStart);
		bit extraSent;
		bit busyDropped;
		currentTest = testName;
		buildExpected(length);
		magnitudeCount = 0;
		extraSent = 1'b0;
		busyDropped = 1'b0;
		@(negedge clock);
		dataLength = memAddrT'(length);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		while (done !== 1'b1) begin
			if (busy !== 1'b1) begin
				busyDropped = 1'b1;
			end
			@(negedge clock);
			// a second start while the data streams must be ignored.
			start = 1'b0;
			if (extraStart && !extraSent && magnitudeValid === 1'b1) begin
				start = 1'b1;
				extraSent = 1'b1;
			end
		end
		start = 1'b0;
		checkTotal++;
		if (busyDropped || busy !== 1'b0) begin
			errorCount++;
			$display("%s: busy did not stay high from start until done", testName);
		end
		checkCount(testName, memAddrT'(length), memAddrT'(magnitudeCount));
	endtask

	initial begin
		void'($urandom(63815));
		arstN = 1'b0;
		start = 1'b0;
		dataLength = '0;
		hostWrite = '0;
		currentTest = "reset";
		for (int a = 0; a < Depth; a++) begin
			tbMemory[a] = '0;
		end
		repeat (ResetCycles) @(negedge clock);
		arstN = 1'b1;

		currentTest = "idle";
		checkIdle();

		currentTest = "impulse";
		loadImpulseCoefficients();
		loadRandomData(0, ImpulseLength);
		runFilter("impulse", ImpulseLength, 1'b0);

		currentTest = "random";
		loadRandomCoefficients();
		loadRandomData(0, RandomLength);
		runFilter("random", RandomLength, 1'b0);

		// next block goes in just above the region being read.
		fork
			runFilter("hostOverlap", RandomLength, 1'b0);
			begin
				repeat (40) @(negedge clock);
				loadRandomData(RandomLength, HostBlock);
			end
		join
		runFilter("hostReadBack", OverlapLength, 1'b0);

		runFilter("backToBackFirst", FirstLength, 1'b1);
		runFilter("backToBackSecond", SecondLength, 1'b0);

		currentTest = "final";
		repeat (20) @(negedge clock);
		$display("Checks: %0d, errors: %0d", checkTotal, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+include
source/mfSamplePkg.sv
source/mfMemoryPkg.sv
source/sampleMemory.sv
source/memoryArbiter.sv
source/memoryReader.sv
source/hilbertTransform.sv
source/complexFir.sv
source/magnitudeEstimator.sv
source/filterSequencer.sv
source/matchedFilter.sv
verif/matchedFilterTb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module matchedFilterTb \
	-o matchedFilterSim && ./obj_dir/matchedFilterSim | tee sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
